// File: group_norm_top.f
hw/group_norm_pkg.sv
hw/step_counter.sv
hw/group_norm_ctrl.sv
hw/beat_buffer.sv
hw/group_stats.sv
hw/isqrt_search.sv
hw/norm_lanes.sv
hw/group_norm_top.sv
verification/group_norm_tb.sv

// File: verification/group_norm_tb.sv
// Table-driven testbench for the group norm unit, run as top with random output stalls
module group_norm_tb;

    import group_norm_pkg::*;

    localparam int FIXED_GROUPS = 4;
    localparam int NUM_GROUPS = FIXED_GROUPS + 20;
    localparam int TIMEOUT_CYCLES = 200;

    logic      clk = 1'b0;
    logic      reset;
    beat_t     in_data;
    logic      in_valid;
    logic      in_ready;
    out_beat_t out_data;
    logic      out_valid;
    logic      out_ready;

    // One row per group indexed by beat * LANES + lane
    sample_t     in_samples [NUM_GROUPS][NUM_VALUES];
    out_sample_t exp_samples [NUM_GROUPS][NUM_VALUES];

    // Monitor state
    int        in_beats;
    int        out_beats;
    logic      holding;
    logic      stall_seen;
    out_beat_t held_data;

    group_norm_top dut (
        .clk(clk),
        .reset(reset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: the %s never came within %0d cycles", what, TIMEOUT_CYCLES);
        stop_with_failure();
    endtask

    // Reference model of mean, variance, root and scaled output
    function automatic void build_expected(input int g);
        int     sum;
        int     mu;
        int     d;
        longint sq_sum;
        longint v;
        longint r;
        longint scaled;
        sum = 0;
        for (int i = 0; i < NUM_VALUES; i++) begin
            sum += in_samples[g][i];
        end
        mu = sum >>> 4;
        sq_sum = 0;
        for (int i = 0; i < NUM_VALUES; i++) begin
            d = in_samples[g][i] - mu;
            sq_sum += d * d;
        end
        v = sq_sum >>> 4;
        if (v > 65535) begin
            v = 65535;
        end
        // Linear search for the largest r with r*r*v <= 2^24
        if (v == 0) begin
            r = 65535;
        end else begin
            r = 0;
            while ((r + 1) * (r + 1) * v <= (longint'(1) << 24)) begin
                r++;
            end
        end
        for (int i = 0; i < NUM_VALUES; i++) begin
            d = in_samples[g][i] - mu;
            scaled = (d * r) >>> 8;
            if (scaled > 127) begin
                scaled = 127;
            end else if (scaled < -128) begin
                scaled = -128;
            end
            exp_samples[g][i] = out_sample_t'(scaled);
        end
    endfunction

    task automatic fill_groups();
        int amplitude;
        int value;
        // Flat, ramp, single outlier, then near-flat which saturates both ways
        for (int i = 0; i < NUM_VALUES; i++) begin
            in_samples[0][i] = 8'sd40;
            in_samples[1][i] = sample_t'(i * 8 - 64);
            in_samples[2][i] = (i == 5) ? 8'sd127 : -8'sd16;
            in_samples[3][i] = (i < 13) ? 8'sd0 : (i < 15) ? 8'sd1 : -8'sd1;
        end
        for (int g = FIXED_GROUPS; g < NUM_GROUPS; g++) begin
            amplitude = 1 << ($urandom % 8);
            for (int i = 0; i < NUM_VALUES; i++) begin
                value = int'($urandom % (2 * amplitude)) - amplitude;
                in_samples[g][i] = sample_t'(value);
            end
        end
        for (int g = 0; g < NUM_GROUPS; g++) begin
            build_expected(g);
        end
    endtask

    task automatic send_groups();
        beat_t beat;
        int    waited;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int b = 0; b < BEATS; b++) begin
                for (int l = 0; l < LANES; l++) begin
                    beat[l] = in_samples[g][b * LANES + l];
                end
                in_data <= beat;
                in_valid <= 1'b1;
                waited = 0;
                @(posedge clk);
                while (!in_ready) begin
                    waited++;
                    if (waited >= TIMEOUT_CYCLES) begin
                        report_timeout("input handshake");
                    end
                    @(posedge clk);
                end
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic receive_groups();
        out_beat_t expected;
        int        waited;
        logic      accepted;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int b = 0; b < BEATS; b++) begin
                for (int l = 0; l < LANES; l++) begin
                    expected[l] = exp_samples[g][b * LANES + l];
                end
                waited = 0;
                accepted = 1'b0;
                while (!accepted) begin
                    @(posedge clk);
                    accepted = out_valid && out_ready;
                    out_ready <= ($urandom % 4) != 0;
                    waited++;
                    if (!accepted && waited >= TIMEOUT_CYCLES) begin
                        report_timeout("output handshake");
                    end
                end
                check_value($sformatf("out_data group %0d beat %0d", g, b), out_data, expected);
            end
        end
        out_ready <= 1'b0;
    endtask

    // in_ready low while a group is held, and stalled outputs stay put
    always @(posedge clk) begin
        if (reset) begin
            in_beats = 0;
            out_beats = 0;
            holding = 1'b0;
            stall_seen = 1'b0;
        end else begin
            check_value("in_ready", in_ready, !holding);
            if (stall_seen) begin
                check_value("out_valid", out_valid, 1'b1);
                check_value("out_data", out_data, held_data);
            end
            stall_seen = out_valid && !out_ready;
            held_data = out_data;
            if (in_valid && in_ready) begin
                in_beats++;
                if (in_beats == BEATS) begin
                    in_beats = 0;
                    holding = 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                out_beats++;
                if (out_beats == BEATS) begin
                    out_beats = 0;
                    holding = 1'b0;
                end
            end
        end
    end

    initial begin
        void'($urandom(93));
        reset <= 1'b1;
        in_data <= '0;
        in_valid <= 1'b0;
        out_ready <= 1'b0;
        fill_groups();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("in_ready", in_ready, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
        @(posedge clk);
        fork
            send_groups();
            receive_groups();
        join
        @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: hw/group_norm_top.sv
// Top level of the group norm unit, with a valid/ready beat stream in and out
module group_norm_top (
    input  logic                      clk,
    input  logic                      reset,
    input  group_norm_pkg::beat_t     in_data,
    input  logic                      in_valid,
    output logic                      in_ready,
    output group_norm_pkg::out_beat_t out_data,
    output logic                      out_valid,
    input  logic                      out_ready
);

    import group_norm_pkg::*;

    logic [BEAT_IDX_WIDTH-1:0] beat_index;
    logic                      beat_last;
    logic                      beat_clear;
    logic                      beat_enable;
    logic                      write_enable;
    logic                      stats_clear;
    logic                      sum_enable;
    logic                      square_enable;
    logic                      root_start;
    logic                      root_done;
    beat_t                     stored_beat;
    sample_t                   mean;
    var_t                      variance;
    root_t                     root;

    group_norm_ctrl ctrl (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .beat_last(beat_last),
        .beat_clear(beat_clear),
        .beat_enable(beat_enable),
        .write_enable(write_enable),
        .stats_clear(stats_clear),
        .sum_enable(sum_enable),
        .square_enable(square_enable),
        .root_start(root_start),
        .root_done(root_done)
    );

    // Shared index for buffer writes and both replays
    step_counter #(
        .MAX(BEATS)
    ) beat_index_counter (
        .clk(clk),
        .reset(reset),
        .clear(beat_clear),
        .enable(beat_enable),
        .count(beat_index),
        .last(beat_last)
    );

    beat_buffer buffer (
        .clk(clk),
        .reset(reset),
        .write_enable(write_enable),
        .index(beat_index),
        .write_data(in_data),
        .read_data(stored_beat)
    );

    // Sum path sees the incoming beat, square path the replayed one
    group_stats stats (
        .clk(clk),
        .reset(reset),
        .clear(stats_clear),
        .sum_enable(sum_enable),
        .square_enable(square_enable),
        .beat(sum_enable ? in_data : stored_beat),
        .mean(mean),
        .variance(variance)
    );

    isqrt_search isqrt (
        .clk(clk),
        .reset(reset),
        .start(root_start),
        .variance(variance),
        .root(root),
        .done(root_done)
    );

    norm_lanes lanes (
        .beat(stored_beat),
        .mean(mean),
        .root(root),
        .out_beat(out_data)
    );

endmodule

// File: hw/norm_lanes.sv
// Combinational lane array that scales each deviation by the root and saturates the result
module norm_lanes (
    input  group_norm_pkg::beat_t     beat,
    input  group_norm_pkg::sample_t   mean,
    input  group_norm_pkg::root_t     root,
    output group_norm_pkg::out_beat_t out_beat
);

    import group_norm_pkg::*;

    for (genvar i = 0; i < LANES; i++) begin : lane
        diff_t                        diff;
        logic signed [NORM_WIDTH-1:0] product;
        logic signed [NORM_WIDTH-1:0] scaled;

        assign diff = beat[i] - mean;

        // Root is unsigned, zero sign bit added
        assign product = diff * $signed({1'b0, root});

        // Arithmetic shift floors toward minus infinity
        assign scaled = product >>> ISQRT_SHIFT;

        assign out_beat[i] = (scaled > OUT_MAX) ? OUT_MAX :
                             (scaled < OUT_MIN) ? OUT_MIN : out_sample_t'(scaled);
    end

endmodule

// File: hw/isqrt_search.sv
// Bit-serial search for the largest root whose square times the variance stays under the target
module isqrt_search (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  group_norm_pkg::var_t variance,
    output group_norm_pkg::root_t root,
    output logic                 done
);

    import group_norm_pkg::*;

    logic [$clog2(ISQRT_WIDTH)-1:0]          bit_count;
    logic                                    bit_last;
    logic                                    busy;
    root_t                                   trial;
    logic [2*ISQRT_WIDTH+VAR_WIDTH-1:0]      trial_product;

    step_counter #(
        .MAX(ISQRT_WIDTH)
    ) bit_counter (
        .clk(clk),
        .reset(reset),
        .clear(start),
        .enable(busy),
        .count(bit_count),
        .last(bit_last)
    );

    // Current root plus the bit under test, MSB first
    assign trial = root | (root_t'(1) << (ISQRT_WIDTH - 1 - bit_count));
    assign trial_product = trial * trial * variance;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            root <= '0;
        end else begin
            done <= busy && bit_last;
            if (start) begin
                root <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                // Keep the bit if r*r*v does not pass the target
                if (trial_product <= (1 << ROOT_TARGET_SHIFT)) begin
                    root <= trial;
                end
                if (bit_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hw/group_stats.sv
// Sum and squared-deviation accumulators giving the group mean and the clamped variance
module group_stats (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clear,
    input  logic                    sum_enable,
    input  logic                    square_enable,
    input  group_norm_pkg::beat_t   beat,
    output group_norm_pkg::sample_t mean,
    output group_norm_pkg::var_t    variance
);

    import group_norm_pkg::*;

    logic signed [SUM_WIDTH-1:0]    sum;
    logic signed [SUM_WIDTH-1:0]    beat_sum;
    logic signed [SQ_SUM_WIDTH-1:0] sq_sum;
    logic signed [SQ_SUM_WIDTH-1:0] beat_sq_sum;
    logic signed [SQ_SUM_WIDTH-1:0] sq_scaled;
    diff_t                          lane_diff [LANES];
    logic signed [SQUARE_WIDTH-1:0] lane_sq [LANES];

    // Lane sums of the current beat
    always_comb begin
        beat_sum = '0;
        beat_sq_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            lane_diff[i] = beat[i] - mean;
            lane_sq[i] = lane_diff[i] * lane_diff[i];
            beat_sum = beat_sum + beat[i];
            beat_sq_sum = beat_sq_sum + lane_sq[i];
        end
    end

    // Divide by the group size with a shift
    assign mean = sample_t'(sum >>> LOG2_VALUES);
    assign sq_scaled = sq_sum >>> LOG2_VALUES;

    // Saturate anything above the variance range
    assign variance = (|sq_scaled[SQ_SUM_WIDTH-1:VAR_WIDTH]) ? '1 : sq_scaled[VAR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            sum <= '0;
            sq_sum <= '0;
        end else begin
            if (sum_enable) begin
                sum <= sum + beat_sum;
            end
            // Mean is final here since loading is complete
            if (square_enable) begin
                sq_sum <= sq_sum + beat_sq_sum;
            end
        end
    end

endmodule

// File: hw/beat_buffer.sv
// Register array holding one group of beats, written in arrival order and replayed by index
module beat_buffer (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      write_enable,
    input  logic [group_norm_pkg::BEAT_IDX_WIDTH-1:0] index,
    input  group_norm_pkg::beat_t                     write_data,
    output group_norm_pkg::beat_t                     read_data
);

    import group_norm_pkg::*;

    beat_t beats [BEATS];

    // Combinational read so each replay beat is ready in the same cycle
    assign read_data = beats[index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BEATS; i++) begin
                beats[i] <= '0;
            end
        end else if (write_enable) begin
            beats[index] <= write_data;
        end
    end

endmodule

// File: hw/group_norm_ctrl.sv
// FSM that sequences load, square pass, root search and emit for each group of beats
module group_norm_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    output logic out_valid,
    input  logic out_ready,
    input  logic beat_last,
    output logic beat_clear,
    output logic beat_enable,
    output logic write_enable,
    output logic stats_clear,
    output logic sum_enable,
    output logic square_enable,
    output logic root_start,
    input  logic root_done
);

    typedef enum logic [1:0] {
        LOAD,
        SQUARE,
        ROOT,
        EMIT
    } state_t;

    state_t state;
    state_t state_next;
    logic   root_started;
    logic   in_fire;
    logic   out_fire;

    assign in_ready = (state == LOAD);
    assign out_valid = (state == EMIT);
    assign in_fire = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // Each accepted beat is stored and summed
    assign write_enable = in_fire;
    assign sum_enable = in_fire;
    assign square_enable = (state == SQUARE);
    assign beat_enable = in_fire || square_enable || out_fire;

    // Index parked at zero while the root is searched
    assign beat_clear = (state == ROOT);

    // Empty the accumulators as the last output beat leaves
    assign stats_clear = out_fire && beat_last;

    // Start only in the first ROOT cycle
    assign root_start = (state == ROOT) && !root_started;

    always_comb begin
        state_next = state;
        case (state)
            LOAD: begin
                if (in_fire && beat_last) begin
                    state_next = SQUARE;
                end
            end
            SQUARE: begin
                if (beat_last) begin
                    state_next = ROOT;
                end
            end
            ROOT: begin
                if (root_done) begin
                    state_next = EMIT;
                end
            end
            EMIT: begin
                if (out_fire && beat_last) begin
                    state_next = LOAD;
                end
            end
            default: state_next = LOAD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOAD;
            root_started <= 1'b0;
        end else begin
            state <= state_next;
            root_started <= (state == ROOT);
        end
    end

endmodule

// File: hw/step_counter.sv
// Clearable up-counter with a terminal-count flag, used to step through beats and search bits
module step_counter #(
    parameter int MAX = 4
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    clear,
    input  logic                                    enable,
    output logic [$clog2((MAX > 1) ? MAX : 2)-1:0]  count,
    output logic                                    last
);

    assign last = (count == MAX - 1);

    // Clear wins over enable
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (enable) begin
            if (last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: hw/group_norm_pkg.sv
// Group shape, fixed-point formats and sample types shared by every block of the norm unit
package group_norm_pkg;

    // Group shape
    localparam int LANES = 4;
    localparam int BEATS = 4;
    localparam int NUM_VALUES = LANES * BEATS;
    localparam int LOG2_VALUES = $clog2(NUM_VALUES);
    localparam int BEAT_IDX_WIDTH = $clog2(BEATS);

    // FRAC counts the fractional bits of each format
    localparam int IN_WIDTH = 8;
    localparam int IN_FRAC = 4;
    localparam int OUT_WIDTH = 8;
    localparam int OUT_FRAC = 4;
    localparam int DIFF_WIDTH = IN_WIDTH + 1;
    localparam int VAR_WIDTH = 16;
    localparam int VAR_FRAC = 2 * IN_FRAC;
    localparam int ISQRT_WIDTH = 16;
    localparam int ISQRT_FRAC = 8;

    // One in the format of root squared times variance
    localparam int ROOT_TARGET_SHIFT = 2 * ISQRT_FRAC + VAR_FRAC;
    // Deviation times root back to output format
    localparam int ISQRT_SHIFT = IN_FRAC + ISQRT_FRAC - OUT_FRAC;

    // Accumulator and product widths
    localparam int SUM_WIDTH = IN_WIDTH + LOG2_VALUES;
    localparam int SQUARE_WIDTH = 2 * DIFF_WIDTH;
    localparam int SQ_SUM_WIDTH = SQUARE_WIDTH + LOG2_VALUES;
    localparam int NORM_WIDTH = DIFF_WIDTH + ISQRT_WIDTH + 1;

    typedef logic signed [IN_WIDTH-1:0] sample_t;
    typedef sample_t [LANES-1:0] beat_t;
    typedef logic signed [DIFF_WIDTH-1:0] diff_t;
    typedef logic signed [OUT_WIDTH-1:0] out_sample_t;
    typedef out_sample_t [LANES-1:0] out_beat_t;
    typedef logic [VAR_WIDTH-1:0] var_t;
    typedef logic [ISQRT_WIDTH-1:0] root_t;

    // Saturation limits of an output sample
    localparam out_sample_t OUT_MAX = out_sample_t'(2 ** (OUT_WIDTH - 1) - 1);
    localparam out_sample_t OUT_MIN = out_sample_t'(-(2 ** (OUT_WIDTH - 1)));

endpackage
